/* Bender.yml */
package:
  name: hni_qos

export_include_dirs:
  - .

sources:
  - files:
      - hni_qos_pkg.sv
      - hni_qos_fifo.sv
      - hni_qos_pool.sv
      - hni_qos_mshr_tracker.sv
      - hni_qos_retry_bank.sv
      - hni_qos.sv
  - target: test
    files:
      - hni_qos_checker.sv
      - tb_clk_gen.sv
      - tb_hni_qos.sv

/* hni_qos.sv */
// HN-I QoS admission top level: pool, tracker, retry bank, retry-ack and grant queues
`default_nettype none
`include "hni_qos_config.svh"

module hni_qos (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              req_valid,
    input  wire hni_qos_pkg::req_flit_t      req_flit,
    input  wire                              retire_valid,
    input  wire hni_qos_pkg::mshr_idx_t      retire_idx,
    input  wire                              retry_ack_won,
    input  wire                              pcrd_grant_won,
    output logic                             req_alloc,
    output logic                             req_retry,
    output hni_qos_pkg::mshr_idx_t           alloc_idx,
    output logic                             retry_ack_valid,
    output hni_qos_pkg::retry_ack_t          retry_ack,
    output logic                             pcrd_grant_valid,
    output hni_qos_pkg::pcrd_grant_t         pcrd_grant
);
    hni_qos_pkg::qos_class_e  alloc_class;
    hni_qos_pkg::qos_class_e  retire_class;
    hni_qos_pkg::retry_ack_t  retry_word;
    hni_qos_pkg::pcrd_grant_t grant_word;
    logic                     alloc_dyn;
    logic                     alloc_static;
    logic                     grant_win;
    logic                     retry_push;
    logic                     grant_push;
    logic                     retry_ackq_empty;
    logic                     retry_ackq_full;
    logic                     pcrdgnt_q_empty;
    logic                     pcrdgnt_q_full;

    hni_qos_pool u_pool (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_flit(req_flit),
        .retire_valid(retire_valid), .retire_class(retire_class), .grant_win(grant_win),
        .req_alloc(req_alloc), .req_retry(req_retry), .alloc_dyn(alloc_dyn),
        .alloc_static(alloc_static), .alloc_class(alloc_class),
        .retry_push(retry_push), .retry_word(retry_word)
    );

    hni_qos_mshr_tracker u_tracker (
        .clk(clk), .rst(rst), .alloc_dyn(alloc_dyn), .alloc_static(alloc_static),
        .alloc_class(alloc_class), .retire_valid(retire_valid), .retire_idx(retire_idx),
        .grant_win(grant_win), .alloc_idx(alloc_idx), .retire_class(retire_class)
    );

    hni_qos_retry_bank u_retry_bank (
        .clk(clk), .rst(rst), .req_retry(req_retry), .req_flit(req_flit),
        .retire_valid(retire_valid), .retire_class(retire_class), .grant_win(grant_win),
        .grant_push(grant_push), .grant_word(grant_word)
    );

    // retry acks visible the cycle after the rejected request
    hni_qos_fifo #(.payload_t(hni_qos_pkg::retry_ack_t), .DEPTH(`HNI_RETRY_ACKQ_DEPTH)) u_retry_ackq (
        .clk(clk), .rst(rst), .push(retry_push), .push_data(retry_word),
        .pop(retry_ack_won), .head(retry_ack), .empty(retry_ackq_empty), .full(retry_ackq_full)
    );

    hni_qos_fifo #(.payload_t(hni_qos_pkg::pcrd_grant_t), .DEPTH(`HNI_PCRDGNT_DEPTH)) u_pcrdgnt_q (
        .clk(clk), .rst(rst), .push(grant_push), .push_data(grant_word),
        .pop(pcrd_grant_won), .head(pcrd_grant), .empty(pcrdgnt_q_empty), .full(pcrdgnt_q_full)
    );

    assign retry_ack_valid  = ~retry_ackq_empty;
    assign pcrd_grant_valid = ~pcrdgnt_q_empty;

endmodule

`default_nettype wire

/* hni_qos_checker.sv */
// concurrent assertions on request outcome, reset state and queue overflow, bound to hni_qos
`default_nettype none

module hni_qos_checker (
    input wire clk,
    input wire rst,
    input wire req_valid,
    input wire req_alloc,
    input wire req_retry,
    input wire retry_ack_valid,
    input wire pcrd_grant_valid,
    input wire retry_push,
    input wire retry_full,
    input wire retry_pop,
    input wire grant_push,
    input wire grant_full,
    input wire grant_pop
);
    timeunit 1ns;
    timeprecision 1ps;

    int err_cnt = 0;

    a_outcome_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(req_alloc && req_retry))
        else begin
            err_cnt++;
            $error("req_alloc and req_retry high together");
        end

    a_outcome_one: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (req_alloc ^ req_retry))
        else begin
            err_cnt++;
            $error("valid request without exactly one outcome");
        end

    a_reset_idle: assert property (@(posedge clk)
        rst |-> (!retry_ack_valid && !pcrd_grant_valid))
        else begin
            err_cnt++;
            $error("queue valid set during reset");
        end

    // a full queue only takes a push together with a pop
    a_retry_no_loss: assert property (@(posedge clk) disable iff (rst)
        !(retry_push && retry_full && !retry_pop))
        else begin
            err_cnt++;
            $error("retry ack pushed into full queue");
        end

    a_grant_no_loss: assert property (@(posedge clk) disable iff (rst)
        !(grant_push && grant_full && !grant_pop))
        else begin
            err_cnt++;
            $error("grant pushed into full queue");
        end

endmodule

bind hni_qos hni_qos_checker u_checker (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .req_alloc(req_alloc),
    .req_retry(req_retry),
    .retry_ack_valid(retry_ack_valid),
    .pcrd_grant_valid(pcrd_grant_valid),
    .retry_push(retry_push),
    .retry_full(retry_ackq_full),
    .retry_pop(retry_ack_won),
    .grant_push(grant_push),
    .grant_full(pcrdgnt_q_full),
    .grant_pop(pcrd_grant_won)
);

`default_nettype wire

/* hni_qos_config.svh */
// entry counts, pool sizes, field widths, QoS threshold and queue depths
`ifndef HNI_QOS_CONFIG_SVH
`define HNI_QOS_CONFIG_SVH

`define HNI_MSHR_ENTRIES      8
`define HNI_MSHR_IDX_WIDTH    3
`define HNI_HIGH_POOL         3
`define HNI_LOW_POOL          4
`define HNI_POOL_CNT_WIDTH    3
`define HNI_RET_BANK_ENTRIES  4
`define HNI_RET_CNT_WIDTH     3
`define HNI_QOS_HIGH_MIN      8

`define HNI_SRCID_WIDTH       7
`define HNI_TXNID_WIDTH       8
`define HNI_QOS_WIDTH         4
`define HNI_PCRD_TYPE_WIDTH   4

`define HNI_RETRY_ACKQ_DEPTH  4
`define HNI_PCRDGNT_DEPTH     4

`endif

/* hni_qos_fifo.sv */
// synchronous FIFO with a type-parameter payload, read and write pointers and a count
`default_nettype none

module hni_qos_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           push,
    input  wire payload_t push_data,
    input  wire           pop,
    output payload_t      head,
    output logic          empty,
    output logic          full
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          do_push;
    logic          do_pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty  = (count_q == '0);
    assign full   = (count_q == CW'(DEPTH));
    assign do_pop = pop & ~empty;
    // full queue takes a push only alongside a pop
    assign do_push = push & (~full | do_pop);
    assign head    = mem[rd_ptr_q];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q <= count_q + CW'(do_push) - CW'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

endmodule

`default_nettype wire

/* hni_qos_mshr_tracker.sv */
// tracker entries: valid and reserved-static bits, pool class per entry, lowest-free search
`default_nettype none
`include "hni_qos_config.svh"

module hni_qos_mshr_tracker (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              alloc_dyn,
    input  wire                              alloc_static,
    input  wire hni_qos_pkg::qos_class_e     alloc_class,
    input  wire                              retire_valid,
    input  wire hni_qos_pkg::mshr_idx_t      retire_idx,
    input  wire                              grant_win,
    output hni_qos_pkg::mshr_idx_t           alloc_idx,
    output hni_qos_pkg::qos_class_e          retire_class
);
    localparam int N = `HNI_MSHR_ENTRIES;

    hni_qos_pkg::mshr_vec_t  valid_q;
    hni_qos_pkg::mshr_vec_t  rsv_q;
    hni_qos_pkg::mshr_vec_t  dyn_free;
    hni_qos_pkg::mshr_vec_t  static_free;
    hni_qos_pkg::mshr_idx_t  dyn_idx;
    hni_qos_pkg::mshr_idx_t  static_idx;
    hni_qos_pkg::qos_class_e class_q [N];

    // scan from the top so the lowest set bit is written last
    function automatic hni_qos_pkg::mshr_idx_t lowest_set(input hni_qos_pkg::mshr_vec_t vec);
        hni_qos_pkg::mshr_idx_t idx;
        idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = hni_qos_pkg::mshr_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // dynamic requests skip entries held for a granted retry
    assign dyn_free    = ~valid_q & ~rsv_q;
    assign static_free = rsv_q & ~valid_q;

    assign dyn_idx    = lowest_set(dyn_free);
    assign static_idx = lowest_set(static_free);
    assign alloc_idx  = alloc_static ? static_idx : dyn_idx;

    assign retire_class = class_q[retire_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            rsv_q   <= '0;
            for (int i = 0; i < N; i++) begin
                class_q[i] <= hni_qos_pkg::CLASS_LOW;
            end
        end else begin
            if (retire_valid) begin
                valid_q[retire_idx] <= 1'b0;
                if (grant_win) begin
                    rsv_q[retire_idx] <= 1'b1;
                end
            end
            if (alloc_dyn | alloc_static) begin
                valid_q[alloc_idx] <= 1'b1;
            end
            if (alloc_static) begin
                rsv_q[alloc_idx] <= 1'b0;
            end
            // static entries keep the class of the slot they inherited
            if (alloc_dyn) begin
                class_q[alloc_idx] <= alloc_class;
            end
        end
    end

endmodule

`default_nettype wire

/* hni_qos_pkg.sv */
// flit and queue-word types, tracker index and vector, QoS class and class helpers
`default_nettype none
`include "hni_qos_config.svh"

package hni_qos_pkg;

    typedef logic [`HNI_SRCID_WIDTH-1:0]     srcid_t;
    typedef logic [`HNI_TXNID_WIDTH-1:0]     txnid_t;
    typedef logic [`HNI_QOS_WIDTH-1:0]       qos_t;
    typedef logic [`HNI_PCRD_TYPE_WIDTH-1:0] pcrd_type_t;
    typedef logic [`HNI_MSHR_IDX_WIDTH-1:0]  mshr_idx_t;
    typedef logic [`HNI_MSHR_ENTRIES-1:0]    mshr_vec_t;

    typedef enum logic {
        CLASS_LOW  = 1'b0,
        CLASS_HIGH = 1'b1
    } qos_class_e;

    localparam pcrd_type_t PCRD_LOW  = 4'd1;
    localparam pcrd_type_t PCRD_HIGH = 4'd2;

    typedef struct packed {
        srcid_t srcid;
        txnid_t txnid;
        qos_t   qos;
        logic   allow_retry;
    } req_flit_t;

    typedef struct packed {
        srcid_t     srcid;
        txnid_t     txnid;
        qos_t       qos;
        pcrd_type_t pcrd_type;
    } retry_ack_t;

    typedef struct packed {
        srcid_t     srcid;
        qos_t       qos;
        pcrd_type_t pcrd_type;
    } pcrd_grant_t;

    // single threshold, no middle band
    function automatic qos_class_e qos_class(input qos_t qos);
        return (qos >= qos_t'(`HNI_QOS_HIGH_MIN)) ? CLASS_HIGH : CLASS_LOW;
    endfunction

    function automatic pcrd_type_t class_pcrd(input qos_class_e cls);
        return (cls == CLASS_HIGH) ? PCRD_HIGH : PCRD_LOW;
    endfunction

endpackage

`default_nettype wire

/* hni_qos_pool.sv */
// QoS pool: class decode, dynamic and static admission, high and low pool counters
`default_nettype none
`include "hni_qos_config.svh"

module hni_qos_pool (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              req_valid,
    input  wire hni_qos_pkg::req_flit_t      req_flit,
    input  wire                              retire_valid,
    input  wire hni_qos_pkg::qos_class_e     retire_class,
    input  wire                              grant_win,
    output logic                             req_alloc,
    output logic                             req_retry,
    output logic                             alloc_dyn,
    output logic                             alloc_static,
    output hni_qos_pkg::qos_class_e          alloc_class,
    output logic                             retry_push,
    output hni_qos_pkg::retry_ack_t          retry_word
);
    localparam int CW = `HNI_POOL_CNT_WIDTH;

    hni_qos_pkg::qos_class_e req_class;
    logic                    req_dyn;
    logic                    take_high;
    logic                    take_low;
    logic                    high_dec;
    logic                    low_dec;
    logic [CW-1:0]           high_cnt_q;
    logic [CW-1:0]           low_cnt_q;
    logic [CW-1:0]           high_cnt_d;
    logic [CW-1:0]           low_cnt_d;
    logic                    high_full_q;
    logic                    low_full_q;

    assign req_class = hni_qos_pkg::qos_class(req_flit.qos);
    assign req_dyn   = req_valid & req_flit.allow_retry;

    // high requests overflow into the low pool
    assign take_high = req_dyn & (req_class == hni_qos_pkg::CLASS_HIGH) & ~high_full_q;
    assign take_low  = req_dyn & ~take_high & ~low_full_q;

    assign alloc_dyn    = take_high | take_low;
    assign alloc_static = req_valid & ~req_flit.allow_retry;
    assign alloc_class  = take_high ? hni_qos_pkg::CLASS_HIGH : hni_qos_pkg::CLASS_LOW;
    assign req_alloc    = alloc_dyn | alloc_static;
    assign req_retry    = req_dyn & ~alloc_dyn;
    assign retry_push   = req_retry;

    always_comb begin
        retry_word.srcid     = req_flit.srcid;
        retry_word.txnid     = req_flit.txnid;
        retry_word.qos       = req_flit.qos;
        retry_word.pcrd_type = hni_qos_pkg::class_pcrd(req_class);
    end

    // a granted retirement keeps its slot, now reserved for the static retry
    assign high_dec = retire_valid & ~grant_win & (retire_class == hni_qos_pkg::CLASS_HIGH);
    assign low_dec  = retire_valid & ~grant_win & (retire_class == hni_qos_pkg::CLASS_LOW);

    assign high_cnt_d = high_cnt_q + CW'(take_high) - CW'(high_dec);
    assign low_cnt_d  = low_cnt_q + CW'(take_low) - CW'(low_dec);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            high_cnt_q  <= '0;
            low_cnt_q   <= '0;
            high_full_q <= 1'b0;
            low_full_q  <= 1'b0;
        end else begin
            high_cnt_q  <= high_cnt_d;
            low_cnt_q   <= low_cnt_d;
            high_full_q <= (high_cnt_d == CW'(`HNI_HIGH_POOL));
            low_full_q  <= (low_cnt_d == CW'(`HNI_LOW_POOL));
        end
    end

endmodule

`default_nettype wire

/* hni_qos_retry_bank.sv */
// retry bank: source-ID entries, per-class waiter counts, grant decision and grant word
`default_nettype none
`include "hni_qos_config.svh"

module hni_qos_retry_bank (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              req_retry,
    input  wire hni_qos_pkg::req_flit_t      req_flit,
    input  wire                              retire_valid,
    input  wire hni_qos_pkg::qos_class_e     retire_class,
    output logic                             grant_win,
    output logic                             grant_push,
    output hni_qos_pkg::pcrd_grant_t         grant_word
);
    localparam int M  = `HNI_RET_BANK_ENTRIES;
    localparam int RW = (M > 1) ? $clog2(M) : 1;
    localparam int CW = `HNI_RET_CNT_WIDTH;

    hni_qos_pkg::srcid_t srcid_q [M];
    logic [CW-1:0]       h_cnt_q [M];
    logic [CW-1:0]       l_cnt_q [M];
    logic [CW-1:0]       h_cnt_d [M];
    logic [CW-1:0]       l_cnt_d [M];
    logic [M-1:0]        bank_v_q;
    logic [RW-1:0]       claim_ptr_q;
    logic [M-1:0]        match_vec;
    logic [M-1:0]        claim_vec;
    logic [M-1:0]        inc_vec;
    logic [M-1:0]        h_nz;
    logic [M-1:0]        l_nz;
    logic [M-1:0]        h_win_vec;
    logic [M-1:0]        l_win_vec;
    logic [M-1:0]        win_vec;
    logic                claim;
    logic                req_high;
    logic                grant_high;
    logic                grant_low;
    hni_qos_pkg::srcid_t win_srcid;

    always_comb begin
        for (int i = 0; i < M; i++) begin
            match_vec[i] = bank_v_q[i] & (srcid_q[i] == req_flit.srcid);
            claim_vec[i] = (claim_ptr_q == RW'(i));
            h_nz[i]      = (h_cnt_q[i] != '0);
            l_nz[i]      = (l_cnt_q[i] != '0);
        end
    end

    // unknown requester claims the next entry in rotation
    assign claim    = req_retry & ~(|match_vec);
    assign inc_vec  = {M{req_retry}} & (claim ? claim_vec : match_vec);
    assign req_high = (hni_qos_pkg::qos_class(req_flit.qos) == hni_qos_pkg::CLASS_HIGH);

    // high waiters take any retiring slot, low waiters only a low one
    assign grant_high = retire_valid & (|h_nz);
    assign grant_low  = retire_valid & ~(|h_nz) & (|l_nz) &
                        (retire_class == hni_qos_pkg::CLASS_LOW);
    assign grant_win  = grant_high | grant_low;

    // isolate lowest non-zero entry
    assign h_win_vec = h_nz & (~h_nz + M'(1));
    assign l_win_vec = l_nz & (~l_nz + M'(1));
    assign win_vec   = grant_high ? h_win_vec : l_win_vec;

    always_comb begin
        win_srcid = '0;
        for (int i = 0; i < M; i++) begin
            if (win_vec[i]) begin
                win_srcid = srcid_q[i];
            end
            // saturate instead of wrapping
            h_cnt_d[i] = h_cnt_q[i] + CW'(inc_vec[i] & req_high & ~(&h_cnt_q[i]))
                         - CW'(grant_high & h_win_vec[i]);
            l_cnt_d[i] = l_cnt_q[i] + CW'(inc_vec[i] & ~req_high & ~(&l_cnt_q[i]))
                         - CW'(grant_low & l_win_vec[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_v_q    <= '0;
            claim_ptr_q <= '0;
            grant_push  <= 1'b0;
            for (int i = 0; i < M; i++) begin
                h_cnt_q[i] <= '0;
                l_cnt_q[i] <= '0;
            end
        end else begin
            if (claim) begin
                bank_v_q[claim_ptr_q] <= 1'b1;
                claim_ptr_q <= (claim_ptr_q == RW'(M - 1)) ? '0 : claim_ptr_q + 1'b1;
            end
            for (int i = 0; i < M; i++) begin
                h_cnt_q[i] <= h_cnt_d[i];
                l_cnt_q[i] <= l_cnt_d[i];
            end
            grant_push <= grant_win;
        end
    end

    always_ff @(posedge clk) begin
        if (claim) begin
            srcid_q[claim_ptr_q] <= req_flit.srcid;
        end
        // QoS is all ones for a high grant, zero for a low one
        if (grant_win) begin
            grant_word.srcid     <= win_srcid;
            grant_word.qos       <= {$bits(hni_qos_pkg::qos_t){grant_high}};
            grant_word.pcrd_type <= grant_high ? hni_qos_pkg::PCRD_HIGH : hni_qos_pkg::PCRD_LOW;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
hni_qos_pkg.sv
hni_qos_fifo.sv
hni_qos_pool.sv
hni_qos_mshr_tracker.sv
hni_qos_retry_bank.sv
hni_qos.sv
hni_qos_checker.sv
tb_clk_gen.sv
tb_hni_qos.sv

/* tb_clk_gen.sv */
// testbench clock and reset generator
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    // start low so the asynchronous resets see a rising edge
    initial begin
        rst = 1'b0;
        #1;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_hni_qos.sv */
// table-driven testbench for the HN-I QoS stage: compare tasks, queue waits, result report
`default_nettype none

module tb_hni_qos;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OP_REQ     = 0;
    localparam int OP_RETIRE  = 1;
    localparam int OP_POP_ACK = 2;
    localparam int OP_POP_GNT = 3;
    localparam int NROWS      = 19;
    localparam int WAIT_LIMIT = 20;

    // g_type holds the credit type of the popped word
    // 0 on a grant pop means no grant may appear
    typedef struct {
        int op;
        int srcid;
        int qos;
        int dyn;
        int idx;
        int exp_alloc;
        int g_srcid;
        int g_qos;
        int g_type;
    } row_t;

    logic                     clk;
    logic                     rst;
    logic                     req_valid;
    hni_qos_pkg::req_flit_t   req_flit;
    logic                     retire_valid;
    hni_qos_pkg::mshr_idx_t   retire_idx;
    logic                     retry_ack_won;
    logic                     pcrd_grant_won;
    logic                     req_alloc;
    logic                     req_retry;
    hni_qos_pkg::mshr_idx_t   alloc_idx;
    logic                     retry_ack_valid;
    hni_qos_pkg::retry_ack_t  retry_ack;
    logic                     pcrd_grant_valid;
    hni_qos_pkg::pcrd_grant_t pcrd_grant;
    row_t                     table_q [NROWS];
    int                       pass_cnt;
    int                       fail_cnt;

    tb_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    hni_qos u_dut (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_flit(req_flit),
        .retire_valid(retire_valid), .retire_idx(retire_idx),
        .retry_ack_won(retry_ack_won), .pcrd_grant_won(pcrd_grant_won),
        .req_alloc(req_alloc), .req_retry(req_retry), .alloc_idx(alloc_idx),
        .retry_ack_valid(retry_ack_valid), .retry_ack(retry_ack),
        .pcrd_grant_valid(pcrd_grant_valid), .pcrd_grant(pcrd_grant)
    );

    task automatic check_alloc(input int row, input logic got_alloc, input logic got_retry,
                               input hni_qos_pkg::mshr_idx_t got_idx, input logic exp_alloc,
                               input hni_qos_pkg::mshr_idx_t exp_idx);
        logic ok;
        ok = (got_alloc === exp_alloc) && (got_retry === ~exp_alloc);
        if (exp_alloc && (got_idx !== exp_idx)) begin
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
            $display("row %0d: request %s, idx %0d", row, exp_alloc ? "accepted" : "retried",
                     got_idx);
        end else begin
            fail_cnt++;
            $display("MISMATCH at %0t: row %0d alloc %b retry %b idx %0d, exp alloc %b idx %0d",
                     $time, row, got_alloc, got_retry, got_idx, exp_alloc, exp_idx);
        end
    endtask

    task automatic check_retry_ack(input int row, input hni_qos_pkg::retry_ack_t got,
                                   input hni_qos_pkg::retry_ack_t exp);
        if (got === exp) begin
            pass_cnt++;
            $display("row %0d: retry ack ok, srcid %0d type %0d", row, got.srcid, got.pcrd_type);
        end else begin
            fail_cnt++;
            $display("MISMATCH at %0t: row %0d retry ack %h, expected %h", $time, row, got, exp);
        end
    endtask

    task automatic check_grant(input int row, input hni_qos_pkg::pcrd_grant_t got,
                               input hni_qos_pkg::pcrd_grant_t exp);
        if (got === exp) begin
            pass_cnt++;
            $display("row %0d: grant ok, srcid %0d qos %0d", row, got.srcid, got.qos);
        end else begin
            fail_cnt++;
            $display("MISMATCH at %0t: row %0d grant %h, expected %h", $time, row, got, exp);
        end
    endtask

    // polls a queue valid at falling edges until it rises or the limit runs out
    task automatic wait_queue_valid(input int row, input logic grant_q, output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = grant_q ? pcrd_grant_valid : retry_ack_valid;
            n++;
        end
        if (!seen) begin
            fail_cnt++;
            $display("row %0d: timeout, the %s queue never showed valid", row,
                     grant_q ? "grant" : "retry ack");
        end
    endtask

    task automatic expect_no_grant(input int row);
        int   n;
        logic seen;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = pcrd_grant_valid;
            n++;
        end
        if (seen) begin
            fail_cnt++;
            $display("MISMATCH at %0t: row %0d grant %h appeared, none expected",
                     $time, row, pcrd_grant);
        end else begin
            pass_cnt++;
            $display("row %0d: no grant, as expected", row);
        end
    endtask

    initial begin : main
        hni_qos_pkg::retry_ack_t  exp_ack;
        hni_qos_pkg::pcrd_grant_t exp_gnt;
        hni_qos_pkg::txnid_t      last_txnid;
        int                       last_srcid;
        int                       last_qos;
        int                       n;
        logic                     seen;
        row_t                     r;

        req_valid      = 1'b0;
        req_flit       = '0;
        retire_valid   = 1'b0;
        retire_idx     = '0;
        retry_ack_won  = 1'b0;
        pcrd_grant_won = 1'b0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        last_txnid     = '0;
        last_srcid     = 0;
        last_qos       = 0;
        void'($urandom(32'h9ec1aff8));

        // op, srcid, qos, dyn, idx, exp_alloc, grant srcid, grant qos, grant type
        table_q[0]  = '{OP_REQ, 10, 2, 1, 0, 1, 0, 0, 0};
        table_q[1]  = '{OP_REQ, 11, 3, 1, 1, 1, 0, 0, 0};
        table_q[2]  = '{OP_REQ, 12, 1, 1, 2, 1, 0, 0, 0};
        table_q[3]  = '{OP_REQ, 13, 0, 1, 3, 1, 0, 0, 0};
        table_q[4]  = '{OP_REQ, 20, 5, 1, 0, 0, 0, 0, 0};
        table_q[5]  = '{OP_POP_ACK, 0, 0, 0, 0, 0, 0, 0, 1};
        table_q[6]  = '{OP_REQ, 30, 9, 1, 4, 1, 0, 0, 0};
        table_q[7]  = '{OP_REQ, 31, 12, 1, 5, 1, 0, 0, 0};
        table_q[8]  = '{OP_REQ, 32, 15, 1, 6, 1, 0, 0, 0};
        table_q[9]  = '{OP_REQ, 40, 10, 1, 0, 0, 0, 0, 0};
        table_q[10] = '{OP_POP_ACK, 0, 0, 0, 0, 0, 0, 0, 2};
        table_q[11] = '{OP_RETIRE, 0, 0, 0, 0, 0, 0, 0, 0};
        table_q[12] = '{OP_POP_GNT, 0, 0, 0, 0, 0, 40, 15, 2};
        table_q[13] = '{OP_REQ, 40, 10, 0, 0, 1, 0, 0, 0};
        table_q[14] = '{OP_RETIRE, 0, 0, 0, 1, 0, 0, 0, 0};
        table_q[15] = '{OP_POP_GNT, 0, 0, 0, 0, 0, 20, 0, 1};
        table_q[16] = '{OP_RETIRE, 0, 0, 0, 2, 0, 0, 0, 0};
        table_q[17] = '{OP_POP_GNT, 0, 0, 0, 0, 0, 0, 0, 0};
        table_q[18] = '{OP_REQ, 50, 4, 1, 2, 1, 0, 0, 0};

        @(posedge clk);
        n = 0;
        while (rst !== 1'b0 && n < 40) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            fail_cnt++;
            $display("reset never released");
        end
        @(negedge clk);
        if (retry_ack_valid !== 1'b0 || pcrd_grant_valid !== 1'b0) begin
            fail_cnt++;
            $display("MISMATCH at %0t: queue valid set after reset", $time);
        end

        for (int i = 0; i < NROWS; i++) begin
            r = table_q[i];
            @(posedge clk);
            #1;
            req_valid      = 1'b0;
            retire_valid   = 1'b0;
            retry_ack_won  = 1'b0;
            pcrd_grant_won = 1'b0;
            case (r.op)
                OP_REQ: begin
                    last_txnid           = hni_qos_pkg::txnid_t'($urandom);
                    last_srcid           = r.srcid;
                    last_qos             = r.qos;
                    req_flit.srcid       = hni_qos_pkg::srcid_t'(r.srcid);
                    req_flit.txnid       = last_txnid;
                    req_flit.qos         = hni_qos_pkg::qos_t'(r.qos);
                    req_flit.allow_retry = r.dyn[0];
                    req_valid            = 1'b1;
                    @(negedge clk);
                    check_alloc(i, req_alloc, req_retry, alloc_idx, r.exp_alloc[0],
                                hni_qos_pkg::mshr_idx_t'(r.idx));
                end
                OP_RETIRE: begin
                    retire_idx   = hni_qos_pkg::mshr_idx_t'(r.idx);
                    retire_valid = 1'b1;
                    $display("row %0d: retire idx %0d", i, r.idx);
                end
                OP_POP_ACK: begin
                    exp_ack.srcid     = hni_qos_pkg::srcid_t'(last_srcid);
                    exp_ack.txnid     = last_txnid;
                    exp_ack.qos       = hni_qos_pkg::qos_t'(last_qos);
                    exp_ack.pcrd_type = hni_qos_pkg::pcrd_type_t'(r.g_type);
                    wait_queue_valid(i, 1'b0, seen);
                    if (seen) begin
                        check_retry_ack(i, retry_ack, exp_ack);
                        @(posedge clk);
                        #1;
                        retry_ack_won = 1'b1;
                    end
                end
                default: begin
                    if (r.g_type == 0) begin
                        expect_no_grant(i);
                    end else begin
                        exp_gnt.srcid     = hni_qos_pkg::srcid_t'(r.g_srcid);
                        exp_gnt.qos       = hni_qos_pkg::qos_t'(r.g_qos);
                        exp_gnt.pcrd_type = hni_qos_pkg::pcrd_type_t'(r.g_type);
                        wait_queue_valid(i, 1'b1, seen);
                        if (seen) begin
                            check_grant(i, pcrd_grant, exp_gnt);
                            @(posedge clk);
                            #1;
                            pcrd_grant_won = 1'b1;
                        end
                    end
                end
            endcase
        end
        @(posedge clk);
        #1;
        req_valid      = 1'b0;
        retire_valid   = 1'b0;
        retry_ack_won  = 1'b0;
        pcrd_grant_won = 1'b0;
        @(posedge clk);

        if (u_dut.u_checker.err_cnt != 0) begin
            fail_cnt += u_dut.u_checker.err_cnt;
            $display("%0d checker assertions failed", u_dut.u_checker.err_cnt);
        end

        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
